// ==== test/i2c_testdata.txt ====
// kind dev reg data expected nack, one 48-bit word per line
// kinds 00 fill, 01 preload, 02 write, 03 read, 04 burst, ff end
0000005a0000
010021800000
0100259c0000
01002dff0000
01000f6c0000
026a4ab70000
036a4a00b700
036a0f006c00
040000000000
03500f000001
026a2a550000
040000000000
02502a110001
036a2a005500
ff0000000000

// ==== project.f ====
+incdir+logic
logic/i2c_bus_pkg.sv
logic/imu_pkg.sv
logic/i2c_bit_timer.sv
logic/i2c_seq_fsm.sv
logic/i2c_byte_shifter.sv
logic/imu_sample_store.sv
logic/i2c_sensor_top.sv
test/imu_target_model.sv
test/i2c_properties.sv
test/tb_i2c_sensor.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the I2C sensor testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_i2c_sensor -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with errors" "$LOG"; then
	exit 1
fi
exit 0

// ==== test/tb_i2c_sensor.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C IMU master testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "i2c_config.svh"

module tb_i2c_sensor;
	logic                   i2c_clk;
	logic                   rst_n, start, drdy, auto_en;
	i2c_bus_pkg::cmd_op_t   op;
	i2c_bus_pkg::dev_addr_t dev_addr;
	i2c_bus_pkg::byte_t     reg_addr, wr_data, rd_data;
	logic                   busy, done, nack, scl_oe, sda_oe, tgt_sda_oe, scl, sda;
	imu_pkg::sample_t       temp, gyro_x, gyro_y, gyro_z, acc_x, acc_y, acc_z;

	logic [47:0]            records [0:31]; // kind dev reg data exp nack
	i2c_bus_pkg::byte_t     shadow [0:255];
	imu_pkg::sample_t       exp_samp [0:6];
	i2c_bus_pkg::byte_t     exp_rd;
	int                     error_count = 0;
	int                     check_count = 0;
	int                     cycle_cnt = 0;
	int                     timeout_limit = 32'h7fff_ffff;

	assign scl = !scl_oe; // target never stretches
	assign sda = !(sda_oe || tgt_sda_oe);

	i2c_sensor_top i2c_sensor_top_inst (
		.i2c_clk, .i_rst_n(rst_n), .i_start(start), .i_op(op), .i_dev_addr(dev_addr),
		.i_reg_addr(reg_addr), .i_wr_data(wr_data), .i_drdy(drdy), .i_auto_en(auto_en),
		.i_scl(scl), .i_sda(sda), .o_busy(busy), .o_done(done), .o_nack(nack),
		.o_rd_data(rd_data), .o_temp(temp), .o_gyro_x(gyro_x), .o_gyro_y(gyro_y),
		.o_gyro_z(gyro_z), .o_acc_x(acc_x), .o_acc_y(acc_y), .o_acc_z(acc_z),
		.o_scl_oe(scl_oe), .o_sda_oe(sda_oe)
	);

	imu_target_model target_inst (
		.i2c_clk, .i_rst_n(rst_n), .i_scl(scl), .i_sda(sda), .o_sda_oe(tgt_sda_oe)
	);

	bind i2c_sensor_top i2c_properties props_inst (
		.i2c_clk(i2c_clk), .i_rst_n(i_rst_n), .i_busy(o_busy), .i_done(o_done),
		.i_scl_oe(o_scl_oe), .i_sda_oe(o_sda_oe)
	);

	initial begin
		i2c_clk = 1'b0;
		forever #50 i2c_clk = ~i2c_clk;
	end

	always @(posedge i2c_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt > timeout_limit) begin
			$display("timeout: the DUT did not finish its work within %0d cycles", timeout_limit);
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic check_byte(input i2c_bus_pkg::byte_t got, input i2c_bus_pkg::byte_t exp,
			input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_sample(input imu_pkg::sample_t got, input imu_pkg::sample_t exp,
			input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_outputs();
		check_byte(rd_data, exp_rd, "o_rd_data");
		check_sample(temp, exp_samp[imu_pkg::S_TEMP], "o_temp");
		check_sample(gyro_x, exp_samp[imu_pkg::S_GYRO_X], "o_gyro_x");
		check_sample(gyro_y, exp_samp[imu_pkg::S_GYRO_Y], "o_gyro_y");
		check_sample(gyro_z, exp_samp[imu_pkg::S_GYRO_Z], "o_gyro_z");
		check_sample(acc_x, exp_samp[imu_pkg::S_ACC_X], "o_acc_x");
		check_sample(acc_y, exp_samp[imu_pkg::S_ACC_Y], "o_acc_y");
		check_sample(acc_z, exp_samp[imu_pkg::S_ACC_Z], "o_acc_z");
	endtask

	// outputs are read on the falling edge, away from updates
	task automatic wait_done();
		@(negedge i2c_clk);
		while (!done)
			@(negedge i2c_clk);
		check_flag(busy, 1'b0, "o_busy at done");
	endtask

	task automatic run_cpu_op(input i2c_bus_pkg::cmd_op_t o, input i2c_bus_pkg::dev_addr_t d,
			input i2c_bus_pkg::byte_t r, input i2c_bus_pkg::byte_t w);
		@(posedge i2c_clk);
		start    <= 1'b1;
		op       <= o;
		dev_addr <= d;
		reg_addr <= r;
		wr_data  <= w;
		@(posedge i2c_clk);
		start <= 1'b0;
		wait_done();
	endtask

	task automatic run_burst();
		@(posedge i2c_clk);
		drdy <= 1'b1;
		repeat (3) @(posedge i2c_clk);
		drdy <= 1'b0;
		wait_done();
	endtask

	// little endian pair from the sensor map
	function automatic imu_pkg::sample_t expected_sample(input int k);
		return {shadow[`IMU_BURST_REG + 2*k + 1], shadow[`IMU_BURST_REG + 2*k]};
	endfunction

	initial begin
		int                 n_rec;
		logic [7:0]         kind;
		i2c_bus_pkg::byte_t rg, dt, ex;
		logic               ex_nack;

		void'($urandom(32'h98fe_f691));
		rst_n     = 1'b0;
		start     = 1'b0;
		drdy      = 1'b0;
		auto_en   = 1'b1;
		op        = i2c_bus_pkg::OP_WRITE;
		dev_addr  = '0;
		reg_addr  = '0;
		wr_data   = '0;
		exp_rd    = '0;
		for (int k = 0; k < `IMU_SAMPLES; k++)
			exp_samp[k] = '0;

		$readmemh("test/i2c_testdata.txt", records);
		n_rec = 0;
		while (n_rec < 32 && records[n_rec][47:40] !== 8'hff)
			n_rec++;
		timeout_limit = n_rec * 200 * 20;

		for (int i = 0; i < n_rec; i++) begin
			dt = records[i][23:16];
			if (records[i][47:40] == 8'h00) begin
				for (int a = 0; a < 256; a++) begin
					shadow[a] = 8'(a * 29) ^ dt;
					target_inst.preload(8'(a), shadow[a]);
				end
			end else if (records[i][47:40] == 8'h01) begin
				shadow[records[i][31:24]] = dt;
				target_inst.preload(records[i][31:24], dt);
			end
		end

		repeat (4) @(posedge i2c_clk);
		rst_n <= 1'b1;
		@(negedge i2c_clk);
		check_flag(busy, 1'b0, "o_busy after reset");
		check_flag(done, 1'b0, "o_done after reset");
		check_flag(nack, 1'b0, "o_nack after reset");
		check_flag(scl_oe, 1'b0, "o_scl_oe after reset");
		check_flag(sda_oe, 1'b0, "o_sda_oe after reset");
		check_outputs();

		for (int i = 0; i < n_rec; i++) begin
			kind    = records[i][47:40];
			rg      = records[i][31:24];
			dt      = records[i][23:16];
			ex      = records[i][15:8];
			ex_nack = records[i][0];
			if (kind >= 8'h02 && kind <= 8'h04) begin
				case (kind)
					8'h02: run_cpu_op(i2c_bus_pkg::OP_WRITE, records[i][38:32], rg, dt);
					8'h03: run_cpu_op(i2c_bus_pkg::OP_READ, records[i][38:32], rg, 8'h00);
					default: run_burst();
				endcase
				check_flag(nack, ex_nack, "o_nack");
				if (!ex_nack) begin
					if (kind == 8'h02)
						shadow[rg] = dt;
					else if (kind == 8'h03)
						exp_rd = ex;
					else
						for (int k = 0; k < `IMU_SAMPLES; k++)
							exp_samp[k] = expected_sample(k);
				end
				check_outputs();
				repeat ($urandom % 16) @(posedge i2c_clk);
			end
		end

		error_count += i2c_sensor_top_inst.props_inst.fail_count;
		$display("checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== test/i2c_properties.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C top handshake checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_properties (
	input logic i2c_clk,
	input logic i_rst_n,
	input logic i_busy,
	input logic i_done,
	input logic i_scl_oe,
	input logic i_sda_oe
);
	int fail_count = 0; // read by the testbench at the end

	done_single: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		i_done |=> !i_done)
	else begin
		$error("o_done held longer than one cycle");
		fail_count++;
	end

	done_on_busy_fall: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		i_done |-> $fell(i_busy))
	else begin
		$error("o_done without o_busy falling");
		fail_count++;
	end

	busy_fall_has_done: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		$fell(i_busy) |-> i_done)
	else begin
		$error("o_busy fell without o_done");
		fail_count++;
	end

	idle_bus_released: assert property (@(posedge i2c_clk) disable iff (!i_rst_n)
		!i_busy |-> (!i_scl_oe && !i_sda_oe))
	else begin
		$error("bus driven while idle");
		fail_count++;
	end

endmodule

// ==== test/imu_target_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IMU I2C target model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "i2c_config.svh"

module imu_target_model (
	input  logic i2c_clk,
	input  logic i_rst_n,
	input  logic i_scl,
	input  logic i_sda,
	output logic o_sda_oe
);
	typedef enum logic [2:0] {T_IDLE, T_ADDR, T_REG, T_WRITE, T_READ} tmode_t;

	logic [7:0] regs [0:255];
	tmode_t     mode;
	logic       scl_q, sda_q, ack_drive;
	logic [3:0] bitn;
	logic [7:0] sh, tx, ptr;

	task preload(input logic [7:0] addr, input logic [7:0] data);
		regs[addr] <= data;
	endtask

	// bus levels sampled on the system clock, edges seen one cycle late
	always @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			mode      <= T_IDLE;
			scl_q     <= 1'b1;
			sda_q     <= 1'b1;
			o_sda_oe  <= 1'b0;
			ack_drive <= 1'b0;
			bitn      <= '0;
			sh        <= '0;
			tx        <= '0;
			ptr       <= '0;
		end else begin
			scl_q <= i_scl;
			sda_q <= i_sda;
			if (i_scl && scl_q && sda_q && !i_sda) begin
				mode      <= T_ADDR; // start or repeated start
				bitn      <= '0;
				o_sda_oe  <= 1'b0;
				ack_drive <= 1'b0;
			end else if (i_scl && scl_q && !sda_q && i_sda) begin
				mode      <= T_IDLE; // stop
				o_sda_oe  <= 1'b0;
				ack_drive <= 1'b0;
			end else if (mode != T_IDLE && i_scl && !scl_q) begin
				if (bitn != 4'd8) begin
					sh   <= {sh[6:0], i_sda};
					bitn <= bitn + 4'd1;
				end else begin
					bitn <= '0;
					if (mode == T_READ && !ack_drive && i_sda)
						mode <= T_IDLE; // master nacked, read ends
				end
			end else if (mode != T_IDLE && !i_scl && scl_q) begin
				if (bitn == 4'd8) begin
					if (mode == T_READ) begin
						o_sda_oe <= 1'b0; // master owns the ack slot
					end else if (mode == T_ADDR && sh[7:1] != `IMU_DEV_ADDR) begin
						mode <= T_IDLE; // not our address
					end else begin
						ack_drive <= 1'b1;
						o_sda_oe  <= 1'b1;
						case (mode)
							T_ADDR:  mode <= sh[0] ? T_READ : T_REG;
							T_REG: begin
								ptr  <= sh;
								mode <= T_WRITE;
							end
							default: begin
								regs[ptr] <= sh;
								ptr       <= ptr + 8'd1;
							end
						endcase
					end
				end else if (bitn == 4'd0) begin
					ack_drive <= 1'b0;
					if (mode == T_READ) begin
						o_sda_oe <= !regs[ptr][7];
						tx       <= {regs[ptr][6:0], 1'b1};
						ptr      <= ptr + 8'd1;
					end else begin
						o_sda_oe <= 1'b0;
					end
				end else if (mode == T_READ) begin
					o_sda_oe <= !tx[7];
					tx       <= {tx[6:0], 1'b1};
				end
			end
		end
	end

endmodule

// ==== logic/i2c_sensor_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C IMU master top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_sensor_top (
	input  logic                    i2c_clk,
	input  logic                    i_rst_n,
	input  logic                    i_start,
	input  i2c_bus_pkg::cmd_op_t    i_op,
	input  i2c_bus_pkg::dev_addr_t  i_dev_addr,
	input  i2c_bus_pkg::byte_t      i_reg_addr,
	input  i2c_bus_pkg::byte_t      i_wr_data,
	input  logic                    i_drdy,
	input  logic                    i_auto_en,
	input  logic                    i_scl,
	input  logic                    i_sda,
	output logic                    o_busy,
	output logic                    o_done,
	output logic                    o_nack,
	output i2c_bus_pkg::byte_t      o_rd_data,
	output imu_pkg::sample_t        o_temp,
	output imu_pkg::sample_t        o_gyro_x,
	output imu_pkg::sample_t        o_gyro_y,
	output imu_pkg::sample_t        o_gyro_z,
	output imu_pkg::sample_t        o_acc_x,
	output imu_pkg::sample_t        o_acc_y,
	output imu_pkg::sample_t        o_acc_z,
	output logic                    o_scl_oe,
	output logic                    o_sda_oe
);
	logic                    run, frame_clr, slot_end, ack_slot, ack_ok;
	logic                    load, capture, commit;
	logic [3:0]              capture_idx;
	i2c_bus_pkg::slot_kind_t slot_kind;
	i2c_bus_pkg::scl_phase_t phase;
	i2c_bus_pkg::sda_mode_t  sda_mode;
	i2c_bus_pkg::byte_t      load_byte, rx_byte;

	i2c_seq_fsm u_fsm (
		.i2c_clk, .i_rst_n, .i_start, .i_op, .i_dev_addr, .i_reg_addr, .i_wr_data,
		.i_drdy, .i_auto_en,
		.i_slot_end(slot_end), .i_ack_slot(ack_slot), .i_ack_ok(ack_ok), .i_rx_byte(rx_byte),
		.o_run(run), .o_slot_kind(slot_kind), .o_frame_clr(frame_clr),
		.o_load(load), .o_load_byte(load_byte), .o_sda_mode(sda_mode),
		.o_capture(capture), .o_capture_idx(capture_idx), .o_commit(commit),
		.o_busy, .o_done, .o_nack, .o_rd_data
	);

	i2c_bit_timer u_timer (
		.i2c_clk, .i_rst_n, .i_run(run), .i_slot_kind(slot_kind), .i_frame_clr(frame_clr),
		.o_phase(phase), .o_slot_end(slot_end), .o_bit_cnt(),
		.o_ack_slot(ack_slot), .o_scl_oe
	);

	i2c_byte_shifter u_shifter (
		.i2c_clk, .i_rst_n, .i_load(load), .i_load_byte(load_byte), .i_sda_mode(sda_mode),
		.i_phase(phase), .i_slot_end(slot_end), .i_sda,
		.o_sda_oe, .o_rx_byte(rx_byte), .o_ack_ok(ack_ok)
	);

	imu_sample_store u_store (
		.i2c_clk, .i_rst_n, .i_capture(capture), .i_capture_idx(capture_idx),
		.i_rx_byte(rx_byte), .i_commit(commit),
		.o_temp, .o_gyro_x, .o_gyro_y, .o_gyro_z, .o_acc_x, .o_acc_y, .o_acc_z
	);

endmodule

// ==== logic/imu_sample_store.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IMU sample store
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "i2c_config.svh"

module imu_sample_store (
	input  logic                 i2c_clk,
	input  logic                 i_rst_n,
	input  logic                 i_capture,
	input  logic [3:0]           i_capture_idx,
	input  i2c_bus_pkg::byte_t   i_rx_byte,
	input  logic                 i_commit,
	output imu_pkg::sample_t     o_temp,
	output imu_pkg::sample_t     o_gyro_x,
	output imu_pkg::sample_t     o_gyro_y,
	output imu_pkg::sample_t     o_gyro_z,
	output imu_pkg::sample_t     o_acc_x,
	output imu_pkg::sample_t     o_acc_y,
	output imu_pkg::sample_t     o_acc_z
);
	i2c_bus_pkg::byte_t stage  [0:`IMU_BURST_BYTES-1];
	imu_pkg::sample_t   samp_q [0:`IMU_SAMPLES-1];

	always_ff @(posedge i2c_clk) begin
		if (i_capture)
			stage[i_capture_idx] <= i_rx_byte;
	end

	// all seven move together so a torn burst never shows
	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int k = 0; k < `IMU_SAMPLES; k++)
				samp_q[k] <= '0;
		end else if (i_commit) begin
			for (int k = 0; k < `IMU_SAMPLES; k++)
				samp_q[k] <= {stage[2*k+1], stage[2*k]}; // low byte first on the wire
		end
	end

	assign o_temp   = samp_q[imu_pkg::S_TEMP];
	assign o_gyro_x = samp_q[imu_pkg::S_GYRO_X];
	assign o_gyro_y = samp_q[imu_pkg::S_GYRO_Y];
	assign o_gyro_z = samp_q[imu_pkg::S_GYRO_Z];
	assign o_acc_x  = samp_q[imu_pkg::S_ACC_X];
	assign o_acc_y  = samp_q[imu_pkg::S_ACC_Y];
	assign o_acc_z  = samp_q[imu_pkg::S_ACC_Z];

endmodule

// ==== logic/i2c_byte_shifter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SDA byte shifter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module i2c_byte_shifter (
	input  logic                      i2c_clk,
	input  logic                      i_rst_n,
	input  logic                      i_load,
	input  i2c_bus_pkg::byte_t        i_load_byte,
	input  i2c_bus_pkg::sda_mode_t    i_sda_mode,
	input  i2c_bus_pkg::scl_phase_t   i_phase,
	input  logic                      i_slot_end,
	input  logic                      i_sda,
	output logic                      o_sda_oe,
	output i2c_bus_pkg::byte_t        o_rx_byte,
	output logic                      o_ack_ok
);
	logic [8:0]              tx_q, rx_q, load_val;
	i2c_bus_pkg::scl_phase_t phase_q;
	logic                    bit_mode, hi_strobe, cur_bit, sda_oe_d;

	assign bit_mode  = (i_sda_mode == i2c_bus_pkg::SDA_TX) ||
	                   (i_sda_mode == i2c_bus_pkg::SDA_RX_ACK) ||
	                   (i_sda_mode == i2c_bus_pkg::SDA_RX_NACK);
	assign hi_strobe = (i_phase == i2c_bus_pkg::PH_HIGH) && (phase_q != i2c_bus_pkg::PH_HIGH);
	// ninth bit is the ack slot, 1 means released
	assign load_val  = {i_load_byte, i_sda_mode != i2c_bus_pkg::SDA_RX_ACK};
	assign cur_bit   = i_load ? load_val[8] : tx_q[8];
	assign o_rx_byte = rx_q[8:1];
	assign o_ack_ok  = !rx_q[0]; // low in the ack slot

	always_comb begin
		case (i_sda_mode)
			i2c_bus_pkg::SDA_START:   sda_oe_d = (i_phase == i2c_bus_pkg::PH_HIGH) ||
			                                     (i_phase == i2c_bus_pkg::PH_LOW2);
			i2c_bus_pkg::SDA_STOP:    sda_oe_d = (i_phase == i2c_bus_pkg::PH_LOW1) ||
			                                     (i_phase == i2c_bus_pkg::PH_RISE);
			i2c_bus_pkg::SDA_TX,
			i2c_bus_pkg::SDA_RX_ACK,
			i2c_bus_pkg::SDA_RX_NACK: sda_oe_d = !cur_bit;
			default:                  sda_oe_d = 1'b0;
		endcase
	end

	// drive lags by a cycle so SDA moves after SCL is already low
	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_sda_oe <= 1'b0;
			phase_q  <= i2c_bus_pkg::PH_LOW1;
		end else begin
			o_sda_oe <= sda_oe_d;
			phase_q  <= i_phase;
		end
	end

	always_ff @(posedge i2c_clk) begin
		if (i_load)
			tx_q <= load_val;
		else if (i_slot_end && bit_mode)
			tx_q <= {tx_q[7:0], 1'b1}; // msb first
		if (hi_strobe && bit_mode)
			rx_q <= {rx_q[7:0], i_sda};
	end

endmodule

// ==== logic/i2c_seq_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C transaction sequencer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_seq_fsm (
	input  logic                      i2c_clk,
	input  logic                      i_rst_n,
	input  logic                      i_start,
	input  i2c_bus_pkg::cmd_op_t      i_op,
	input  i2c_bus_pkg::dev_addr_t    i_dev_addr,
	input  i2c_bus_pkg::byte_t        i_reg_addr,
	input  i2c_bus_pkg::byte_t        i_wr_data,
	input  logic                      i_drdy,
	input  logic                      i_auto_en,
	input  logic                      i_slot_end,
	input  logic                      i_ack_slot,
	input  logic                      i_ack_ok,
	input  i2c_bus_pkg::byte_t        i_rx_byte,
	output logic                      o_run,
	output i2c_bus_pkg::slot_kind_t   o_slot_kind,
	output logic                      o_frame_clr,
	output logic                      o_load,
	output i2c_bus_pkg::byte_t        o_load_byte,
	output i2c_bus_pkg::sda_mode_t    o_sda_mode,
	output logic                      o_capture,
	output logic [3:0]                o_capture_idx,
	output logic                      o_commit,
	output logic                      o_busy,
	output logic                      o_done,
	output logic                      o_nack,
	output i2c_bus_pkg::byte_t        o_rd_data
);
	// slots per transaction: write 29, read 40, burst 157
	typedef enum logic [3:0] {
		IDLE, START, ADDR, REG, WDATA, RESTART, RADDR, RDATA, STOP
	} state_t;

	state_t                 state;
	logic                   drdy_s1, drdy_s2, drdy_s3;
	logic                   burst_pend;
	logic                   seq_rd, seq_burst, rd_phase, nack_q;
	logic [3:0]             byte_cnt;
	i2c_bus_pkg::dev_addr_t dev_q;
	i2c_bus_pkg::byte_t     reg_q, data_q;
	logic                   drdy_rise, byte_end, last_byte;

	assign drdy_rise = drdy_s2 && !drdy_s3;
	assign byte_end  = i_slot_end && i_ack_slot;
	assign last_byte = seq_burst ? (byte_cnt == 4'(`IMU_BURST_BYTES - 1)) : 1'b1;

	always_comb begin
		o_slot_kind = i2c_bus_pkg::SLOT_BIT;
		o_sda_mode  = i2c_bus_pkg::SDA_TX;
		o_frame_clr = 1'b1;
		case (state)
			IDLE: begin
				o_slot_kind = i2c_bus_pkg::SLOT_IDLE;
				o_sda_mode  = i2c_bus_pkg::SDA_RELEASE;
			end
			START, RESTART: begin
				o_slot_kind = i2c_bus_pkg::SLOT_START;
				o_sda_mode  = i2c_bus_pkg::SDA_START;
			end
			STOP: begin
				o_slot_kind = i2c_bus_pkg::SLOT_STOP;
				// wrap-up cycle after the stop slot lets go of SDA
				o_sda_mode  = o_run ? i2c_bus_pkg::SDA_STOP : i2c_bus_pkg::SDA_RELEASE;
			end
			RDATA: begin
				o_sda_mode  = last_byte ? i2c_bus_pkg::SDA_RX_NACK : i2c_bus_pkg::SDA_RX_ACK;
				o_frame_clr = 1'b0;
			end
			default: o_frame_clr = 1'b0;
		endcase
	end

	// request operands, burst uses the fixed sensor map
	always_ff @(posedge i2c_clk) begin
		if (state == IDLE && i_start) begin
			dev_q  <= i_dev_addr;
			reg_q  <= i_reg_addr;
			data_q <= i_wr_data;
		end else if (state == IDLE && burst_pend) begin
			dev_q  <= `IMU_DEV_ADDR;
			reg_q  <= `IMU_BURST_REG;
		end
	end

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state         <= IDLE;
			drdy_s1       <= 1'b0;
			drdy_s2       <= 1'b0;
			drdy_s3       <= 1'b0;
			burst_pend    <= 1'b0;
			seq_rd        <= 1'b0;
			seq_burst     <= 1'b0;
			rd_phase      <= 1'b0;
			nack_q        <= 1'b0;
			byte_cnt      <= '0;
			o_run         <= 1'b0;
			o_load        <= 1'b0;
			o_load_byte   <= '0;
			o_capture     <= 1'b0;
			o_capture_idx <= '0;
			o_commit      <= 1'b0;
			o_busy        <= 1'b0;
			o_done        <= 1'b0;
			o_nack        <= 1'b0;
			o_rd_data     <= '0;
		end else begin
			drdy_s1   <= i_drdy;
			drdy_s2   <= drdy_s1;
			drdy_s3   <= drdy_s2;
			o_load    <= 1'b0;
			o_capture <= 1'b0;
			o_commit  <= 1'b0;
			o_done    <= 1'b0;
			if (drdy_rise && i_auto_en)
				burst_pend <= 1'b1;
			case (state)
				IDLE: begin
					seq_burst <= !i_start && burst_pend;
					seq_rd    <= i_start ? (i_op == i2c_bus_pkg::OP_READ) : 1'b1;
					rd_phase  <= 1'b0;
					nack_q    <= 1'b0;
					if (i_start || burst_pend) begin
						state  <= START;
						o_run  <= 1'b1;
						o_busy <= 1'b1;
					end
					if (!i_start && burst_pend && !(drdy_rise && i_auto_en))
						burst_pend <= 1'b0; // cpu start wins, the request waits
				end
				START, RESTART: if (i_slot_end) begin
					state       <= (state == START) ? ADDR : RADDR;
					o_load      <= 1'b1;
					o_load_byte <= {dev_q, state == RESTART};
				end
				ADDR, RADDR: if (byte_end) begin
					if (!i_ack_ok) begin
						nack_q <= 1'b1; // nobody home, straight to stop
						state  <= STOP;
					end else begin
						state       <= (state == ADDR) ? REG : RDATA;
						byte_cnt    <= '0;
						o_load      <= 1'b1;
						o_load_byte <= (state == ADDR) ? reg_q : 8'hFF;
					end
				end
				REG: if (byte_end) begin
					state       <= seq_rd ? STOP : WDATA;
					o_load      <= !seq_rd;
					o_load_byte <= data_q;
				end
				WDATA: if (byte_end) state <= STOP;
				RDATA: if (byte_end) begin
					o_capture     <= seq_burst;
					o_capture_idx <= byte_cnt;
					if (last_byte) begin
						state <= STOP;
					end else begin
						byte_cnt    <= byte_cnt + 4'd1;
						o_load      <= 1'b1;
						o_load_byte <= 8'hFF; // keeps SDA released
					end
				end
				STOP: begin
					if (i_slot_end && seq_rd && !rd_phase && !nack_q) begin
						state    <= RESTART; // pointer set, now the read phase
						rd_phase <= 1'b1;
					end else if (i_slot_end) begin
						o_run    <= 1'b0;
						o_commit <= seq_burst && !nack_q;
					end else if (!o_run) begin
						state  <= IDLE;
						o_busy <= 1'b0;
						o_done <= 1'b1;
						o_nack <= nack_q;
						if (seq_rd && !seq_burst && !nack_q)
							o_rd_data <= i_rx_byte; // shifter holds it through stop
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

endmodule

// ==== logic/i2c_bit_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SCL slot timer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`include "i2c_config.svh"

module i2c_bit_timer (
	input  logic                      i2c_clk,
	input  logic                      i_rst_n,
	input  logic                      i_run,
	input  i2c_bus_pkg::slot_kind_t   i_slot_kind,
	input  logic                      i_frame_clr,
	output i2c_bus_pkg::scl_phase_t   o_phase,
	output logic                      o_slot_end,
	output logic [3:0]                o_bit_cnt,
	output logic                      o_ack_slot,
	output logic                      o_scl_oe
);
	logic [7:0] qcnt;
	logic       qtr_end;

	assign qtr_end    = (qcnt == 8'(`I2C_QTR_CYCLES - 1));
	assign o_slot_end = i_run && qtr_end && (o_phase == i2c_bus_pkg::PH_LOW2);
	assign o_ack_slot = (o_bit_cnt == 4'd8); // ninth slot of a byte frame

	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			qcnt    <= '0;
			o_phase <= i2c_bus_pkg::PH_LOW1;
		end else if (!i_run) begin
			qcnt    <= '0;
			o_phase <= i2c_bus_pkg::PH_LOW1;
		end else if (qtr_end) begin
			qcnt <= '0;
			case (o_phase)
				i2c_bus_pkg::PH_LOW1: o_phase <= i2c_bus_pkg::PH_RISE;
				i2c_bus_pkg::PH_RISE: o_phase <= i2c_bus_pkg::PH_HIGH;
				i2c_bus_pkg::PH_HIGH: o_phase <= i2c_bus_pkg::PH_LOW2;
				default:              o_phase <= i2c_bus_pkg::PH_LOW1;
			endcase
		end else begin
			qcnt <= qcnt + 8'd1;
		end
	end

	// bit slots 0..8 per byte, start and stop slots keep it cleared
	always_ff @(posedge i2c_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_bit_cnt <= '0;
		end else if (i_frame_clr) begin
			o_bit_cnt <= '0;
		end else if (o_slot_end && i_slot_kind == i2c_bus_pkg::SLOT_BIT) begin
			o_bit_cnt <= o_ack_slot ? 4'd0 : o_bit_cnt + 4'd1;
		end
	end

	always_comb begin
		o_scl_oe = 1'b0; // released when idle and through start slots
		if (i_run) begin
			case (i_slot_kind)
				i2c_bus_pkg::SLOT_BIT:  o_scl_oe = (o_phase == i2c_bus_pkg::PH_LOW1) ||
				                                   (o_phase == i2c_bus_pkg::PH_LOW2);
				i2c_bus_pkg::SLOT_STOP: o_scl_oe = (o_phase == i2c_bus_pkg::PH_LOW1);
				default:                o_scl_oe = 1'b0;
			endcase
		end
	end

endmodule

// ==== logic/imu_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// IMU sample types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package imu_pkg;

	typedef logic signed [15:0] sample_t;

	// register order from 0x20 upward
	typedef enum logic [2:0] {
		S_TEMP,
		S_GYRO_X,
		S_GYRO_Y,
		S_GYRO_Z,
		S_ACC_X,
		S_ACC_Y,
		S_ACC_Z
	} sample_idx_t;

endpackage

// ==== logic/i2c_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C bus types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package i2c_bus_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [6:0] dev_addr_t;

	typedef enum logic [1:0] {OP_WRITE, OP_READ} cmd_op_t;

	// quarters of one bit slot
	typedef enum logic [1:0] {PH_LOW1, PH_RISE, PH_HIGH, PH_LOW2} scl_phase_t;

	typedef enum logic [1:0] {SLOT_IDLE, SLOT_START, SLOT_BIT, SLOT_STOP} slot_kind_t;

	typedef enum logic [2:0] {
		SDA_RELEASE,
		SDA_TX,      // master sends, target acks
		SDA_RX_ACK,  // target sends, master acks
		SDA_RX_NACK, // last byte of a read
		SDA_START,
		SDA_STOP
	} sda_mode_t;

endpackage

// ==== logic/i2c_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// I2C and sensor constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

// i2c_clk cycles per quarter of an SCL period
// one bit slot is four quarters
`define I2C_QTR_CYCLES 5

// sensor address with SA0 tied low
`define IMU_DEV_ADDR 7'h6A

// burst starts at the temperature low byte
`define IMU_BURST_REG 8'h20
`define IMU_BURST_BYTES 14

// temp, gyro x/y/z, accel x/y/z
`define IMU_SAMPLES 7

`endif
